/* edgePkg.sv */
package edgePkg;

    // ==============================
    // window geometry
    // ==============================

    // bits per pixel
    localparam int pixelWidth = 8;
    // rows held in the window
    localparam int windowRows = 3;
    // columns held in the window
    localparam int windowCols = 8;
    // kernel outputs produced by one compute
    localparam int outputCols = 4;
    // index width for a window column
    localparam int windowColBits = $clog2(windowCols);

    // ==============================
    // instruction and control types
    // ==============================

    // opcode lives in valueB[7:0], pixel n sits at row n/8, column n%8
    typedef enum logic [7:0] {
        loadRow0Low  = 8'd0,  // pixels 0-3
        loadRow0High = 8'd1,  // pixels 4-7
        loadRow1Low  = 8'd2,  // pixels 8-11
        loadRow1High = 8'd3,  // pixels 12-15
        loadRow2Low  = 8'd4,  // pixels 16-19
        computeEdges = 8'd5   // pixels 20-23, threshold, direction, then run
    } edgeOpcodeT;

    // controller states
    typedef enum logic [1:0] {
        idle,
        acknowledge,
        compute,
        respond
    } edgeStateT;

    // decoded instruction
    typedef struct packed {
        edgeOpcodeT              opcode;
        // four pixels, lowest byte is the lowest pixel
        logic [31:0]             pixels;
        logic [pixelWidth-1:0]   threshold;
        // 1 selects the reverse column rule
        logic                    reverse;
    } edgeCommandT;

    // 3x3 neighbourhood, row-major from top-left
    typedef struct packed {
        logic [pixelWidth-1:0] p0;
        logic [pixelWidth-1:0] p1;
        logic [pixelWidth-1:0] p2;
        logic [pixelWidth-1:0] p3;
        logic [pixelWidth-1:0] p4;
        logic [pixelWidth-1:0] p5;
        logic [pixelWidth-1:0] p6;
        logic [pixelWidth-1:0] p7;
        logic [pixelWidth-1:0] p8;
    } sobelWindowT;

endpackage

/* pixelWindow.sv */
`timescale 1ns/1ps

module pixelWindow (
    input  logic                clock,
    input  logic                reset,
    input  logic                write,
    input  edgePkg::edgeCommandT command,
    input  logic [1:0]          column,
    output edgePkg::sobelWindowT window,
    output logic [7:0]          threshold
);
    import edgePkg::*;

    // pixel storage, image[row][col]
    logic [pixelWidth-1:0] image [windowRows][windowCols];
    logic [pixelWidth-1:0] thresholdValue;
    logic                  reverseDir;

    // write decode
    logic [7:0]               opcodeBits;
    logic                     writeValid;
    logic [1:0]               writeRow;
    logic [windowColBits-1:0] writeBase;

    // read column selects
    logic [windowColBits-1:0] baseCol;
    logic [windowColBits-1:0] midCol;
    logic [windowColBits-1:0] lastCol;

    // ==============================
    // write side
    // ==============================

    assign opcodeBits = command.opcode;

    // opcodes 0..5 map to row opcode/2, half opcode%2
    // anything above computeEdges writes nothing
    assign writeValid = write && (command.opcode <= computeEdges);
    assign writeRow   = opcodeBits[2:1];
    assign writeBase  = opcodeBits[0] ? windowColBits'(4) : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < windowRows; r++) begin
                for (int c = 0; c < windowCols; c++) begin
                    image[r][c] <= '0;
                end
            end
            thresholdValue <= '0;
            reverseDir     <= 1'b0;
        end else if (writeValid) begin
            for (int k = 0; k < 4; k++) begin
                image[writeRow][writeBase + windowColBits'(k)] <=
                    command.pixels[k*pixelWidth +: pixelWidth];
            end
            // last chunk also carries the compute parameters
            if (command.opcode == computeEdges) begin
                thresholdValue <= command.threshold;
                reverseDir     <= command.reverse;
            end
        end
    end

    // ==============================
    // read side
    // ==============================

    // forward uses columns c..c+2, reverse shifts by four, wrapping mod 8
    always_comb begin
        baseCol = windowColBits'(column) + (reverseDir ? windowColBits'(outputCols) : '0);
        midCol  = baseCol + windowColBits'(1);
        lastCol = baseCol + windowColBits'(2);
    end

    always_comb begin
        window.p0 = image[0][baseCol];
        window.p1 = image[0][midCol];
        window.p2 = image[0][lastCol];
        window.p3 = image[1][baseCol];
        window.p4 = image[1][midCol];
        window.p5 = image[1][lastCol];
        window.p6 = image[2][baseCol];
        window.p7 = image[2][midCol];
        window.p8 = image[2][lastCol];
    end

    assign threshold = thresholdValue;

endmodule

/* sobelKernel.sv */
`timescale 1ns/1ps

module sobelKernel (
    input  edgePkg::sobelWindowT window,
    input  logic [7:0]           threshold,
    output logic [7:0]           edgeByte
);
    import edgePkg::*;

    // weighted sums, up to 4*255 so two extra bits
    logic [pixelWidth+1:0] gxPos;
    logic [pixelWidth+1:0] gxNeg;
    logic [pixelWidth+1:0] gyPos;
    logic [pixelWidth+1:0] gyNeg;

    // signed gradients need one more bit
    logic signed [pixelWidth+2:0] gx;
    logic signed [pixelWidth+2:0] gy;
    logic signed [pixelWidth+2:0] gxNegated;
    logic signed [pixelWidth+2:0] gyNegated;

    logic [pixelWidth+1:0] absGx;
    logic [pixelWidth+1:0] absGy;
    // |gx| + |gy| reaches 2040
    logic [pixelWidth+2:0] magnitudeSum;
    logic [pixelWidth-1:0] magnitude;

    always_comb begin
        // right column minus left column
        gxPos = {2'b00, window.p2} + {1'b0, window.p5, 1'b0} + {2'b00, window.p8};
        gxNeg = {2'b00, window.p0} + {1'b0, window.p3, 1'b0} + {2'b00, window.p6};
        // bottom row minus top row
        gyPos = {2'b00, window.p6} + {1'b0, window.p7, 1'b0} + {2'b00, window.p8};
        gyNeg = {2'b00, window.p0} + {1'b0, window.p1, 1'b0} + {2'b00, window.p2};

        gx = $signed({1'b0, gxPos}) - $signed({1'b0, gxNeg});
        gy = $signed({1'b0, gyPos}) - $signed({1'b0, gyNeg});

        gxNegated = -gx;
        gyNegated = -gy;
        absGx = gx[pixelWidth+2] ? gxNegated[pixelWidth+1:0] : gx[pixelWidth+1:0];
        absGy = gy[pixelWidth+2] ? gyNegated[pixelWidth+1:0] : gy[pixelWidth+1:0];

        magnitudeSum = {1'b0, absGx} + {1'b0, absGy};

        // clamp anything above 255
        if (|magnitudeSum[pixelWidth+2:pixelWidth]) begin
            magnitude = '1;
        end else begin
            magnitude = magnitudeSum[pixelWidth-1:0];
        end

        // strictly greater than threshold counts as an edge
        edgeByte = (magnitude > threshold) ? magnitude : '0;
    end

endmodule

/* columnCounter.sv */
`timescale 1ns/1ps

module columnCounter (
    input  logic       clock,
    input  logic       reset,
    input  logic       countEnable,
    output logic [1:0] column,
    output logic       lastColumn
);
    import edgePkg::*;

    // ==============================
    // modulo-4 column counter
    // ==============================

    always_ff @(posedge clock) begin
        if (reset) begin
            column <= '0;
        end else if (countEnable) begin
            // wraps to 0 after column 3
            column <= column + 2'd1;
        end else begin
            // parked at zero between computes
            column <= '0;
        end
    end

    // final kernel position
    assign lastColumn = (column == 2'(outputCols - 1));

endmodule

/* edgeControl.sv */
`timescale 1ns/1ps

module edgeControl #(
    parameter logic [7:0] customInstructionId = 8'd0
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 start,
    input  logic [7:0]           ciN,
    input  logic [31:0]          valueA,
    input  logic [31:0]          valueB,
    input  logic                 lastColumn,
    output logic                 write,
    output edgePkg::edgeCommandT command,
    output logic                 countEnable,
    output logic                 capture,
    output logic                 clear,
    output logic                 done
);
    import edgePkg::*;

    edgeStateT state;
    edgeStateT nextState;
    logic      accept;

    // ==============================
    // instruction decode
    // ==============================

    // only our own instruction number, and only when not busy
    assign accept = start && (ciN == customInstructionId) && (state == idle);

    always_comb begin
        command.opcode    = edgeOpcodeT'(valueB[7:0]);
        command.pixels    = valueA;
        command.threshold = valueB[15:8];
        command.reverse   = valueB[16];
    end

    // write lands on the accepting edge
    assign write = accept;
    // old result is wiped as a new instruction starts
    assign clear = accept;

    // ==============================
    // state machine
    // ==============================

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (accept) begin
                    // loads and unknown codes just acknowledge
                    nextState = (command.opcode == computeEdges) ? compute : acknowledge;
                end
            end
            acknowledge: nextState = idle;
            compute: begin
                // four columns, one per edge
                if (lastColumn) begin
                    nextState = respond;
                end
            end
            respond: nextState = idle;
            default: nextState = idle;
        endcase
    end

    // counter and collector step together
    assign countEnable = (state == compute);
    assign capture     = (state == compute);

    // one-cycle pulse after a load or after the fourth column
    assign done = (state == acknowledge) || (state == respond);

endmodule

/* resultCollector.sv */
`timescale 1ns/1ps

module resultCollector (
    input  logic        clock,
    input  logic        reset,
    input  logic        capture,
    input  logic        clear,
    input  logic [1:0]  column,
    input  logic [7:0]  edgeByte,
    input  logic        done,
    output logic [31:0] result
);
    import edgePkg::*;

    // one byte lane per output column
    logic [outputCols*pixelWidth-1:0] lanes;

    always_ff @(posedge clock) begin
        if (reset) begin
            lanes <= '0;
        end else if (clear) begin
            lanes <= '0;
        end else if (capture) begin
            // column c goes to bits 8c+7..8c
            lanes[column*pixelWidth +: pixelWidth] <= edgeByte;
        end
    end

    // result bus stays quiet outside the done pulse
    assign result = done ? lanes : '0;

endmodule

/* edgeDetectTop.sv */
`timescale 1ns/1ps

module edgeDetectTop #(
    parameter logic [7:0] customInstructionId = 8'd0
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        start,
    input  logic [7:0]  ciN,
    input  logic [31:0] valueA,
    input  logic [31:0] valueB,
    output logic        done,
    output logic [31:0] result
);
    import edgePkg::*;

    // ==============================
    // internal wiring
    // ==============================

    // control to window
    logic        write;
    edgeCommandT command;

    // control to counter and collector
    logic        countEnable;
    logic        capture;
    logic        clear;

    // counter outputs
    logic [1:0]  column;
    logic        lastColumn;

    // data path
    sobelWindowT window;
    logic [7:0]  threshold;
    logic [7:0]  edgeByte;

    // ==============================
    // control
    // ==============================

    edgeControl #(
        .customInstructionId(customInstructionId)
    ) control0 (
        .clock(clock),
        .reset(reset),
        .start(start),
        .ciN(ciN),
        .valueA(valueA),
        .valueB(valueB),
        .lastColumn(lastColumn),
        .write(write),
        .command(command),
        .countEnable(countEnable),
        .capture(capture),
        .clear(clear),
        .done(done)
    );

    columnCounter counter0 (
        .clock(clock),
        .reset(reset),
        .countEnable(countEnable),
        .column(column),
        .lastColumn(lastColumn)
    );

    // ==============================
    // data path
    // ==============================

    pixelWindow window0 (
        .clock(clock),
        .reset(reset),
        .write(write),
        .command(command),
        .column(column),
        .window(window),
        .threshold(threshold)
    );

    // single kernel shared across the four columns
    sobelKernel kernel0 (
        .window(window),
        .threshold(threshold),
        .edgeByte(edgeByte)
    );

    resultCollector collector0 (
        .clock(clock),
        .reset(reset),
        .capture(capture),
        .clear(clear),
        .column(column),
        .edgeByte(edgeByte),
        .done(done),
        .result(result)
    );

endmodule

/* edgeDetectTb.sv */
`timescale 1ns/1ps

module edgeDetectTb;
    import edgePkg::*;

    localparam logic [7:0] ourId = 8'h2A;
    localparam logic [7:0] foreignId = 8'h15;
    localparam int sequenceCount = 300;
    // loads+compute, random images, edge images, busy/foreign block, unknown opcode
    localparam int instructionCount = 2 + sequenceCount * 6 + 4 * 6 + 10 + 2;
    localparam int cycleLimit = 20 * instructionCount + 100;

    logic        clock;
    logic        reset;
    logic        start;
    logic [7:0]  ciN;
    logic [31:0] valueA;
    logic [31:0] valueB;
    logic        done;
    logic [31:0] result;

    integer seed;
    int     errorCount;
    int     checkCount;
    int     cycleCount;

    // reference image, row-major, pixel n at row n/8 column n%8
    logic [7:0] modelImage [24];
    logic [7:0] modelThreshold;
    logic       modelReverse;
    // image about to be loaded
    logic [7:0] stage [24];

    edgeDetectTop #(.customInstructionId(ourId)) dut0 (
        .clock(clock), .reset(reset), .start(start), .ciN(ciN),
        .valueA(valueA), .valueB(valueB), .done(done), .result(result)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // watchdog
    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("timeout: no finish after %0d cycles", cycleLimit);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    // ==============================
    // reference model
    // ==============================

    task automatic applyModel(input logic [31:0] a, input logic [31:0] b);
        int op;
        op = int'(b[7:0]);
        // unknown codes leave the image alone
        if (op <= int'(computeEdges)) begin
            for (int k = 0; k < 4; k++) begin
                modelImage[op * 4 + k] = a[8 * k +: 8];
            end
            if (op == int'(computeEdges)) begin
                modelThreshold = b[15:8];
                modelReverse   = b[16];
            end
        end
    endtask

    function automatic logic [31:0] expectedEdges();
        int          p [9];
        int          col;
        int          gx;
        int          gy;
        int          mag;
        logic [31:0] word;
        word = '0;
        for (int c = 0; c < 4; c++) begin
            for (int k = 0; k < 3; k++) begin
                // reverse shifts the window by four, wrapping
                col = modelReverse ? (c + 4 + k) % 8 : c + k;
                for (int r = 0; r < 3; r++) begin
                    p[r * 3 + k] = int'(modelImage[r * 8 + col]);
                end
            end
            gx = (p[2] + 2 * p[5] + p[8]) - (p[0] + 2 * p[3] + p[6]);
            gy = (p[6] + 2 * p[7] + p[8]) - (p[0] + 2 * p[1] + p[2]);
            mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
            if (mag > 255) begin
                mag = 255;
            end
            if (mag > int'(modelThreshold)) begin
                word[8 * c +: 8] = 8'(mag);
            end
        end
        return word;
    endfunction

    // ==============================
    // stimulus
    // ==============================

    // called 1 ns after a rising edge, returns 1 ns after one
    // doneCycle is 0 when no done showed up
    task automatic issue(input logic [7:0] id, input logic [31:0] a, input logic [31:0] b,
                         input logic intrude, input logic [31:0] intrudeA,
                         input logic [31:0] intrudeB,
                         output int doneCycle, output logic [31:0] doneResult);
        int   cycles;
        logic seen;
        start  = 1'b1;
        ciN    = id;
        valueA = a;
        valueB = b;
        @(posedge clock);
        #1;
        // a second start held while the unit is busy
        if (intrude) begin
            valueA = intrudeA;
            valueB = intrudeB;
        end else begin
            start = 1'b0;
        end
        cycles = 0;
        seen = 1'b0;
        doneResult = '0;
        while (!seen && cycles < 8) begin
            @(negedge clock);
            cycles++;
            if (done) begin
                seen = 1'b1;
                doneResult = result;
            end else if (intrude && cycles == 1) begin
                @(posedge clock);
                #1;
                start = 1'b0;
            end
        end
        @(posedge clock);
        #1;
        // pulse lasts one cycle only
        if (seen) begin
            checkValue("done after pulse", 32'd0, 32'(done));
        end
        doneCycle = seen ? cycles : 0;
    endtask

    task automatic runLoad(input int op, input logic [31:0] a);
        logic [31:0] b;
        logic [31:0] res;
        int          cycles;
        b = $random(seed);
        b[7:0] = 8'(op);
        issue(ourId, a, b, 1'b0, '0, '0, cycles, res);
        checkValue("load done cycle", 32'd1, cycles);
        checkValue("load result", 32'd0, res);
        applyModel(a, b);
    endtask

    task automatic runCompute(input logic [31:0] a, input logic [7:0] thr, input logic rev,
                              input logic intrude);
        logic [31:0] b;
        logic [31:0] ia;
        logic [31:0] ib;
        logic [31:0] expected;
        logic [31:0] res;
        int          cycles;
        b = $random(seed);
        b[7:0] = computeEdges;
        b[15:8] = thr;
        b[16] = rev;
        // intruder would overwrite row 0 if it got through
        ia = $random(seed);
        ib = $random(seed);
        ib[7:0] = loadRow0Low;
        applyModel(a, b);
        expected = expectedEdges();
        issue(ourId, a, b, intrude, ia, ib, cycles, res);
        checkValue("compute done cycle", 32'd5, cycles);
        checkValue("result", expected, res);
    endtask

    // five loads and a compute from the staged image
    task automatic runImage(input logic [7:0] thr, input logic rev);
        for (int op = 0; op < 5; op++) begin
            runLoad(op, {stage[4 * op + 3], stage[4 * op + 2], stage[4 * op + 1], stage[4 * op]});
        end
        runCompute({stage[23], stage[22], stage[21], stage[20]}, thr, rev, 1'b0);
    endtask

    // ==============================
    // test sequence
    // ==============================

    initial begin
        int          op;
        int          cycles;
        logic [31:0] word;
        logic [31:0] res;
        seed = 32'h8a7c_9493;
        errorCount = 0;
        checkCount = 0;
        reset = 1'b1;
        start = 1'b0;
        ciN = '0;
        valueA = '0;
        valueB = '0;
        for (int i = 0; i < 24; i++) begin
            modelImage[i] = '0;
        end
        modelThreshold = '0;
        modelReverse = 1'b0;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        // quiet after reset
        repeat (5) begin
            @(negedge clock);
            checkValue("done idle", 32'd0, 32'(done));
            checkValue("result idle", 32'd0, result);
        end
        @(posedge clock);
        #1;

        // single random load then compute on it
        op = int'($unsigned($random(seed)) % 5);
        word = $random(seed);
        runLoad(op, word);
        word = $random(seed);
        runCompute(word, 8'd20, 1'b0, 1'b0);

        // random full sequences
        repeat (sequenceCount) begin
            for (int i = 0; i < 24; i++) begin
                stage[i] = 8'($random(seed));
            end
            word = $random(seed);
            runImage(word[7:0], word[8]);
        end

        // all-255, flat, and a vertical step both ways
        for (int i = 0; i < 24; i++) begin
            stage[i] = 8'd255;
        end
        runImage(8'd0, 1'b0);
        for (int i = 0; i < 24; i++) begin
            stage[i] = 8'd77;
        end
        runImage(8'd0, 1'b1);
        for (int i = 0; i < 24; i++) begin
            stage[i] = (i % 8 >= 4) ? 8'd200 : 8'd0;
        end
        runImage(8'd10, 1'b0);
        runImage(8'd10, 1'b1);

        // foreign ciN and a start during compute are both dropped
        for (int i = 0; i < 24; i++) begin
            stage[i] = 8'($random(seed));
        end
        runImage(8'd40, 1'b0);
        word = $random(seed);
        word[7:0] = loadRow0Low;
        issue(foreignId, $random(seed), word, 1'b0, '0, '0, cycles, res);
        checkValue("foreign done cycle", 32'd0, cycles);
        runCompute($random(seed), 8'd30, 1'b0, 1'b1);
        runCompute($random(seed), 8'd30, 1'b1, 1'b0);

        // unknown opcode acknowledges and writes nothing
        op = 6 + int'($unsigned($random(seed)) % 250);
        runLoad(op, $random(seed));
        runCompute($random(seed), 8'd25, 1'b0, 1'b0);

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
edgePkg.sv
pixelWindow.sv
sobelKernel.sv
columnCounter.sv
edgeControl.sv
resultCollector.sv
edgeDetectTop.sv
edgeDetectTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing
LINTFLAGS = --lint-only -Wall --timing
TOP       = edgeDetectTb
RTL_TOP   = edgeDetectTop
FILELIST  = verilog.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
